// File: Bender.yml
package:
  name: uart_tx

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/uart_frame_pkg.sv
      - verilog/uart_ctrl_pkg.sv
      - verilog/tx_control.sv
      - verilog/bit_time_counter.sv
      - verilog/bit_counter.sv
      - verilog/tx_frame_builder.sv
      - verilog/tx_shift_register.sv
      - verilog/uart_tx.sv
      - target: test
        files:
          - test/tb_uart_tx.sv

// File: compile.f
+incdir+verilog
verilog/uart_frame_pkg.sv
verilog/uart_ctrl_pkg.sv
verilog/tx_control.sv
verilog/bit_time_counter.sv
verilog/bit_counter.sv
verilog/tx_frame_builder.sv
verilog/tx_shift_register.sv
verilog/uart_tx.sv
test/tb_uart_tx.sv

// File: test/tb_uart_tx.sv
`timescale 1ns/1ps
`include "uart_tx_config.svh"

module tb_uart_tx;

  // Longest frame in use is code 9 plus margin
  localparam int ready_limit = 12 * `UART_BAUD_CNT_9 + 100;

  logic                      clk;
  logic                      rst;
  logic                      load;
  uart_frame_pkg::byte_t     data_in;
  logic                      eight;
  logic                      p_en;
  logic                      ohel;
  uart_ctrl_pkg::baud_code_t baud;
  logic                      txrdy;
  logic                      tx;

  // Expected frames and their bit times in load order
  uart_frame_pkg::frame_t expected_q[$];
  int                     bit_cycles_q[$];
  int                     frames_accepted = 0;
  int                     frames_seen = 0;
  int                     mismatch_count = 0;
  int                     error_count = 0;
  logic                   checking = 1'b0;

  uart_tx uart_tx_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Bit time for the fast codes 9 to 15 with codes above 11 clamped
  function automatic int cycles_for_code(input int code);
    case (code)
      9:       return `UART_BAUD_CNT_9;
      10:      return `UART_BAUD_CNT_10;
      default: return `UART_BAUD_CNT_11;
    endcase
  endfunction

  //**************************************************************************
  // Reference frame
  //**************************************************************************
  function automatic uart_frame_pkg::frame_t expected_frame(input uart_frame_pkg::byte_t d,
                                                            input logic e,
                                                            input logic p,
                                                            input logic o);
    uart_frame_pkg::frame_t f;
    logic                   par;
    // Odd parity starts from one
    par = o;
    for (int j = 0; j < 7; j++) begin
      par = par ^ d[j];
    end
    if (e) begin
      par = par ^ d[7];
    end
    f[0]   = 1'b1;
    f[1]   = 1'b0;
    f[8:2] = d[6:0];
    f[9]   = e ? d[7] : (p ? par : 1'b1);
    f[10]  = (e && p) ? par : 1'b1;
    return f;
  endfunction

  // Polls txrdy just after each edge for a bounded number of cycles
  task automatic wait_ready(output bit ok);
    int waited;
    waited = 0;
    while (txrdy !== 1'b1 && waited < ready_limit) begin
      @(posedge clk);
      #2;
      waited++;
    end
    ok = (txrdy === 1'b1);
    if (!ok) begin
      error_count++;
      $display("Error at %0t: txrdy did not rise after the frame", $time);
    end
  endtask

  // Loads one byte as soon as the engine is ready
  task automatic send_byte(input uart_frame_pkg::byte_t d, input logic e, input logic p,
                           input logic o, input int code);
    bit ok;
    wait_ready(ok);
    if (ok) begin
      data_in = d;
      eight   = e;
      p_en    = p;
      ohel    = o;
      baud    = uart_ctrl_pkg::baud_code_t'(code);
      load    = 1'b1;
      expected_q.push_back(expected_frame(d, e, p, o));
      bit_cycles_q.push_back(cycles_for_code(code));
      frames_accepted++;
      @(posedge clk);
      #2;
      load = 1'b0;
      if (txrdy !== 1'b0) begin
        mismatch_count++;
        $display("Mismatch at %0t: txrdy expected 0, got %b", $time, txrdy);
      end
    end
  endtask

  //**************************************************************************
  // Serial line checker sampling on the falling clock edge
  //**************************************************************************
  initial begin : serial_checker
    uart_frame_pkg::frame_t exp;
    int                     n;
    int                     waited;
    int                     low_run;
    logic                   run_open;
    waited = 0;
    forever begin
      @(negedge clk);
      if (rst !== 1'b0) begin
        waited = 0;
      end else if (tx === 1'b0 && expected_q.size() == 0) begin
        error_count++;
        $display("Error at %0t: unexpected frame, start bit with no load pending", $time);
        waited = 0;
        while (tx === 1'b0 && waited < ready_limit) begin
          @(negedge clk);
          waited++;
        end
        waited = 0;
      end else if (tx === 1'b0) begin
        exp      = expected_q.pop_front();
        n        = bit_cycles_q.pop_front();
        checking = 1'b1;
        low_run  = 0;
        run_open = 1'b1;
        frames_seen++;
        // Frame bits 1 to 10 sampled mid bit
        for (int i = 0; i < 10 * n; i++) begin
          if (i > 0) begin
            @(negedge clk);
          end
          if (run_open && tx === 1'b0) begin
            low_run++;
          end else begin
            run_open = 1'b0;
          end
          if (i % n == n / 2 && tx !== exp[i / n + 1]) begin
            mismatch_count++;
            $display("Mismatch at %0t: tx bit %0d expected %b, got %b",
                     $time, i / n + 1, exp[i / n + 1], tx);
          end
        end
        // Start bit length only visible when data bit 0 is a mark
        if (exp[2] && (low_run < n - 1 || low_run > n + 1)) begin
          mismatch_count++;
          $display("Mismatch at %0t: tx start bit cycles expected %0d, got %0d",
                   $time, n, low_run);
        end
        checking = 1'b0;
        waited   = 0;
      end else if (expected_q.size() > 0) begin
        waited++;
        if (waited > 2 * bit_cycles_q[0] + 20) begin
          error_count++;
          $display("Error at %0t: timeout, no start bit after an accepted load", $time);
          void'(expected_q.pop_front());
          void'(bit_cycles_q.pop_front());
          waited = 0;
        end
      end
    end
  end

  //**************************************************************************
  // Stimulus
  //**************************************************************************
  initial begin : stimulus
    uart_frame_pkg::byte_t d;
    int                    waited;
    bit                    ok;
    int                    short_codes[5] = '{9, 10, 11, 12, 15};
    void'($urandom(32'h7e7));
    rst     = 1'b1;
    load    = 1'b0;
    data_in = '0;
    eight   = 1'b0;
    p_en    = 1'b0;
    ohel    = 1'b0;
    baud    = 4'd11;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;
    @(posedge clk);
    #2;
    if (tx !== 1'b1 || txrdy !== 1'b1) begin
      mismatch_count++;
      $display("Mismatch at %0t: tx, txrdy expected 1 1, got %b %b", $time, tx, txrdy);
    end
    // Eight data bits and then seven while p_en and ohel walk through all four settings
    for (int i = 0; i < 40; i++) begin
      d = uart_frame_pkg::byte_t'($urandom);
      send_byte(d, i < 20, i[0], i[1], 9 + $urandom % 7);
    end
    // Start bit length per code with odd bytes keeping bit 2 at mark
    foreach (short_codes[k]) begin
      d    = uart_frame_pkg::byte_t'($urandom);
      d[0] = 1'b1;
      send_byte(d, 1'b1, 1'b0, 1'b0, short_codes[k]);
    end
    // Load while busy must be ignored
    d = 8'h5a;
    send_byte(d, 1'b1, 1'b1, 1'b0, 11);
    repeat (20) @(posedge clk);
    #2;
    data_in = ~d;
    load    = 1'b1;
    @(posedge clk);
    #2;
    load = 1'b0;
    wait_ready(ok);
    repeat (4 * `UART_BAUD_CNT_11) @(posedge clk);
    // Drain the checker and then watch an idle line
    waited = 0;
    while ((expected_q.size() > 0 || checking) && waited < ready_limit) begin
      @(posedge clk);
      waited++;
    end
    if (expected_q.size() > 0 || checking) begin
      error_count++;
      $display("Error at %0t: frames still pending at the end of the run", $time);
    end
    repeat (500) @(posedge clk);
    if (frames_seen != frames_accepted) begin
      mismatch_count++;
      $display("Mismatch at %0t: frames on tx expected %0d, got %0d",
               $time, frames_accepted, frames_seen);
    end
    $display("Frames %0d, mismatches %0d, other errors %0d",
             frames_seen, mismatch_count, error_count);
    if (mismatch_count == 0 && error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verilog/bit_counter.sv
`timescale 1ns/1ps
`include "uart_tx_config.svh"

module bit_counter (
  input  logic clk,
  input  logic rst,
  input  logic busy,
  input  logic start_frame,
  input  logic btu,
  output logic frame_done
);

  uart_ctrl_pkg::bit_index_t bit_count;

  // Eleventh bit time closes the frame
  assign frame_done = btu &&
                      (bit_count == uart_ctrl_pkg::bit_index_t'(`UART_FRAME_BITS - 1));

  //**************************************************************************
  // Bit counter
  //**************************************************************************
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      bit_count <= '0;
    end else if (start_frame || !busy) begin
      bit_count <= '0;
    end else if (btu) begin
      if (frame_done) begin
        bit_count <= '0;
      end else begin
        bit_count <= bit_count + 4'd1;
      end
    end
  end

endmodule

// File: verilog/bit_time_counter.sv
`timescale 1ns/1ps
`include "uart_tx_config.svh"

module bit_time_counter (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      busy,
  input  logic                      start_frame,
  input  uart_ctrl_pkg::baud_code_t baud,
  output logic                      btu
);

  uart_ctrl_pkg::bit_time_t bit_cycles;
  uart_ctrl_pkg::bit_time_t count;

  // Baud table where codes above 11 use the fastest rate
  always_comb begin
    case (baud)
      4'd0:    bit_cycles = uart_ctrl_pkg::bit_time_t'(`UART_BAUD_CNT_0);
      4'd1:    bit_cycles = uart_ctrl_pkg::bit_time_t'(`UART_BAUD_CNT_1);
      4'd2:    bit_cycles = uart_ctrl_pkg::bit_time_t'(`UART_BAUD_CNT_2);
      4'd3:    bit_cycles = uart_ctrl_pkg::bit_time_t'(`UART_BAUD_CNT_3);
      4'd4:    bit_cycles = uart_ctrl_pkg::bit_time_t'(`UART_BAUD_CNT_4);
      4'd5:    bit_cycles = uart_ctrl_pkg::bit_time_t'(`UART_BAUD_CNT_5);
      4'd6:    bit_cycles = uart_ctrl_pkg::bit_time_t'(`UART_BAUD_CNT_6);
      4'd7:    bit_cycles = uart_ctrl_pkg::bit_time_t'(`UART_BAUD_CNT_7);
      4'd8:    bit_cycles = uart_ctrl_pkg::bit_time_t'(`UART_BAUD_CNT_8);
      4'd9:    bit_cycles = uart_ctrl_pkg::bit_time_t'(`UART_BAUD_CNT_9);
      4'd10:   bit_cycles = uart_ctrl_pkg::bit_time_t'(`UART_BAUD_CNT_10);
      default: bit_cycles = uart_ctrl_pkg::bit_time_t'(`UART_BAUD_CNT_11);
    endcase
  end

  // One pulse at the end of every bit time
  assign btu = busy && (count == bit_cycles - 18'd1);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (start_frame || !busy) begin
      count <= '0;
    end else if (btu) begin
      count <= '0;
    end else begin
      count <= count + 18'd1;
    end
  end

endmodule

// File: verilog/tx_control.sv
`timescale 1ns/1ps

module tx_control (
  input  logic clk,
  input  logic rst,
  input  logic load,
  input  logic frame_done,
  output logic capture,
  output logic start_frame,
  output logic busy,
  output logic txrdy
);

  uart_ctrl_pkg::tx_state_t state;
  uart_ctrl_pkg::tx_state_t state_next;
  logic                     accept;

  // Host may only load while the engine reports ready
  assign accept = txrdy && load && (state == uart_ctrl_pkg::tx_idle);

  //**************************************************************************
  // Next state
  //**************************************************************************
  always_comb begin
    state_next = state;
    case (state)
      uart_ctrl_pkg::tx_idle: begin
        // Byte was captured last cycle
        if (capture) begin
          state_next = uart_ctrl_pkg::tx_start;
        end
      end
      uart_ctrl_pkg::tx_start: begin
        state_next = uart_ctrl_pkg::tx_send;
      end
      uart_ctrl_pkg::tx_send: begin
        if (frame_done) begin
          state_next = uart_ctrl_pkg::tx_idle;
        end
      end
      default: begin
        state_next = uart_ctrl_pkg::tx_idle;
      end
    endcase
  end

  //**************************************************************************
  // State and registered outputs
  //**************************************************************************
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state       <= uart_ctrl_pkg::tx_idle;
      capture     <= 1'b0;
      start_frame <= 1'b0;
      busy        <= 1'b0;
      txrdy       <= 1'b1;
    end else begin
      state       <= state_next;
      capture     <= accept;
      // Frame starts the cycle after the byte register is loaded
      start_frame <= (state == uart_ctrl_pkg::tx_idle) && capture;
      busy        <= (state_next == uart_ctrl_pkg::tx_send);
      if (accept) begin
        txrdy <= 1'b0;
      end else if ((state == uart_ctrl_pkg::tx_send) && frame_done) begin
        txrdy <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/tx_frame_builder.sv
`timescale 1ns/1ps

module tx_frame_builder (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  capture,
  input  uart_frame_pkg::byte_t data_in,
  input  logic                  eight,
  input  logic                  p_en,
  input  logic                  ohel,
  output uart_frame_pkg::frame_t frame
);

  uart_frame_pkg::byte_t data_q;
  uart_frame_pkg::byte_t data_used;
  logic                  parity;
  logic                  bit9;
  logic                  bit10;

  // Byte held for the whole frame
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      data_q <= '0;
    end else if (capture) begin
      data_q <= data_in;
    end
  end

  //**************************************************************************
  // Parity and upper frame bits
  //**************************************************************************

  // Bit 7 only counts in eight bit mode
  assign data_used = eight ? data_q : {1'b0, data_q[6:0]};

  // Even parity that ohel turns odd
  assign parity = (^data_used) ^ ohel;

  always_comb begin
    if (eight) begin
      bit9  = data_q[7];
      bit10 = p_en ? parity : 1'b1;
    end else begin
      bit9  = p_en ? parity : 1'b1;
      // Second stop bit
      bit10 = 1'b1;
    end
  end

  // Mark, start, data 0..6, bit 9, bit 10
  assign frame = {bit10, bit9, data_q[6:0], 1'b0, 1'b1};

endmodule

// File: verilog/tx_shift_register.sv
`timescale 1ns/1ps
`include "uart_tx_config.svh"

module tx_shift_register (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start_frame,
  input  logic                   btu,
  input  uart_frame_pkg::frame_t frame,
  output logic                   tx
);

  uart_frame_pkg::frame_t shift_q;

  // All ones keeps the line at mark between frames
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      shift_q <= '1;
    end else if (start_frame) begin
      shift_q <= frame;
    end else if (btu) begin
      // LSB first with mark filling from the top
      shift_q <= {1'b1, shift_q[`UART_FRAME_BITS-1:1]};
    end
  end

  assign tx = shift_q[0];

endmodule

// File: verilog/uart_ctrl_pkg.sv
package uart_ctrl_pkg;

  //**************************************************************************
  // Sequencing types
  //**************************************************************************

  // Transmit control FSM
  typedef enum logic [1:0] {
    tx_idle,
    tx_start,
    tx_send
  } tx_state_t;

  // Selects a row of the baud table
  typedef logic [3:0] baud_code_t;

  // Wide enough for the slowest rate (166667 cycles)
  typedef logic [17:0] bit_time_t;

  // Counts up to the eleven bits of a frame
  typedef logic [3:0] bit_index_t;

endpackage

// File: verilog/uart_frame_pkg.sv
package uart_frame_pkg;

  //**************************************************************************
  // Frame contents
  //**************************************************************************

  // Byte as handed over by the host
  typedef logic [7:0] byte_t;

  // Serial frame with bit 0 leaving the engine first
  // [0]    idle mark
  // [1]    start bit
  // [8:2]  data bits 0 to 6
  // [9]    data bit 7, parity or stop
  // [10]   parity or stop
  typedef logic [10:0] frame_t;

endpackage

// File: verilog/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      load,
  input  uart_frame_pkg::byte_t     data_in,
  input  logic                      eight,
  input  logic                      p_en,
  input  logic                      ohel,
  input  uart_ctrl_pkg::baud_code_t baud,
  output logic                      txrdy,
  output logic                      tx
);

  logic                   capture;
  logic                   start_frame;
  logic                   busy;
  logic                   btu;
  logic                   frame_done;
  uart_frame_pkg::frame_t frame;

  //**************************************************************************
  // Sequencing
  //**************************************************************************
  tx_control tx_control_i (
    .clk         (clk),
    .rst         (rst),
    .load        (load),
    .frame_done  (frame_done),
    .capture     (capture),
    .start_frame (start_frame),
    .busy        (busy),
    .txrdy       (txrdy)
  );

  // Bit time from the baud table
  bit_time_counter bit_time_counter_i (
    .clk         (clk),
    .rst         (rst),
    .busy        (busy),
    .start_frame (start_frame),
    .baud        (baud),
    .btu         (btu)
  );

  // Ends the frame after eleven bit times
  bit_counter bit_counter_i (
    .clk         (clk),
    .rst         (rst),
    .busy        (busy),
    .start_frame (start_frame),
    .btu         (btu),
    .frame_done  (frame_done)
  );

  //**************************************************************************
  // Datapath
  //**************************************************************************
  tx_frame_builder tx_frame_builder_i (
    .clk     (clk),
    .rst     (rst),
    .capture (capture),
    .data_in (data_in),
    .eight   (eight),
    .p_en    (p_en),
    .ohel    (ohel),
    .frame   (frame)
  );

  // Serial line driver
  tx_shift_register tx_shift_register_i (
    .clk         (clk),
    .rst         (rst),
    .start_frame (start_frame),
    .btu         (btu),
    .frame       (frame),
    .tx          (tx)
  );

endmodule

// File: verilog/uart_tx_config.svh
`ifndef UART_TX_CONFIG_SVH
`define UART_TX_CONFIG_SVH

// System clock in Hz
`define UART_CLK_HZ 50000000

// Idle mark, start, seven data bits, bit 9 and bit 10
`define UART_FRAME_BITS 11

// Rounded clock cycles per bit for each baud code
`define UART_BAUD_CNT_0  166667
`define UART_BAUD_CNT_1  41667
`define UART_BAUD_CNT_2  20833
`define UART_BAUD_CNT_3  10417
`define UART_BAUD_CNT_4  5208
`define UART_BAUD_CNT_5  2604
`define UART_BAUD_CNT_6  1302
`define UART_BAUD_CNT_7  868
`define UART_BAUD_CNT_8  434
`define UART_BAUD_CNT_9  217
`define UART_BAUD_CNT_10 109
`define UART_BAUD_CNT_11 54

`endif
